// ==== src/timer_pkg.sv ====
// pulse-duration timer shared definitions
// widths, decimal digit counts, report line layout and ascii codes
package timer_pkg;

	// duration counter, saturates at six decimal digits
	localparam int duration_width = 20;
	localparam int duration_digits = 6;
	localparam int duration_limit = 999999;

	// pulse number, wraps after four decimal digits
	localparam int number_width = 14;
	localparam int number_digits = 4;
	localparam int number_limit = 9999;

	// report line: dddddd nnnn cr lf
	localparam int space_position = duration_digits;
	localparam int number_position = space_position + 1;
	localparam int cr_position = number_position + number_digits;
	localparam int lf_position = cr_position + 1;
	localparam int line_length = lf_position + 1;

	// character codes
	localparam logic [7:0] ascii_zero = 8'h30;
	localparam logic [7:0] ascii_space = 8'h20;
	localparam logic [7:0] ascii_cr = 8'h0d;
	localparam logic [7:0] ascii_lf = 8'h0a;

	// one finished pulse, duration in cycles and its running number
	typedef struct packed {
		logic [duration_width-1:0] duration;
		logic [number_width-1:0] pulse_number;
	} measurement_t;

endpackage

// ==== src/pulse_timer.sv ====
// pulse timer
// measures how long the trigger stays high and numbers each pulse
module pulse_timer
	import timer_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic trigger,
	output measurement_t measurement,
	output logic measurement_valid
);

	// [0] and [1] are the synchronizer, [2] the previous synced sample
	logic [2:0] trigger_history;
	logic [duration_width-1:0] high_count;
	logic [number_width-1:0] pulse_count;
	logic [number_width-1:0] next_pulse;
	logic falling_edge;

	// synced trigger was high, now low
	assign falling_edge = (trigger_history[2:1] == 2'b10);

	// wraps 9999 -> 0
	assign next_pulse = (pulse_count == number_width'(number_limit)) ? '0 : pulse_count + 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			trigger_history <= '0;
			high_count <= '0;
			pulse_count <= '0;
			measurement_valid <= 1'b0;
		end else begin
			trigger_history <= {trigger_history[1:0], trigger};
			measurement_valid <= falling_edge;
			if (falling_edge) begin
				// pulse over, restart for the next one
				high_count <= '0;
				pulse_count <= next_pulse;
			end else if (trigger_history[1] && high_count != duration_width'(duration_limit)) begin
				high_count <= high_count + 1'b1;
			end
		end
	end

	// result held until the next falling edge
	always_ff @(posedge clock) begin
		if (falling_edge) begin
			measurement.duration <= high_count;
			measurement.pulse_number <= next_pulse;
		end
	end

	// saturation must hold at the reported value
	assert property (@(posedge clock) disable iff (reset)
		measurement_valid |-> measurement.duration <= duration_width'(duration_limit));

	// one strobe per pulse
	assert property (@(posedge clock) disable iff (reset)
		measurement_valid |=> !measurement_valid);

endmodule

// ==== src/bin_to_bcd.sv ====
// binary to packed decimal converter
// shift-and-add-three, one input bit per clock
module bin_to_bcd #(
	parameter int input_width = 20,
	parameter int number_of_digits = 6
) (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [input_width-1:0] binary,
	output logic [4*number_of_digits-1:0] digits,
	output logic done
);

	localparam int bcd_width = 4 * number_of_digits;
	localparam int count_width = $clog2(input_width + 1);

	// decimal digits on top, remaining binary bits below
	logic [bcd_width+input_width-1:0] work;
	logic [bcd_width+input_width-1:0] work_adjusted;
	logic [count_width-1:0] bits_left;
	logic busy;

	// add three to every digit above four before the shift
	always_comb begin
		work_adjusted = work;
		for (int d = 0; d < number_of_digits; d++) begin
			if (work[input_width+4*d +: 4] > 4'd4)
				work_adjusted[input_width+4*d +: 4] = work[input_width+4*d +: 4] + 4'd3;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			bits_left <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				// start while busy is dropped
				if (start) begin
					busy <= 1'b1;
					bits_left <= count_width'(input_width);
				end
			end else begin
				bits_left <= bits_left - 1'b1;
				// last shift, digits final after this edge
				if (bits_left == count_width'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start && !busy)
			work <= {{bcd_width{1'b0}}, binary};
		else if (busy)
			work <= work_adjusted << 1;
	end

	assign digits = work[bcd_width+input_width-1 -: bcd_width];

	// every digit decimal when presented
	for (genvar d = 0; d < number_of_digits; d++) begin : digit_check
		assert property (@(posedge clock) disable iff (reset)
			done |-> digits[4*d +: 4] <= 4'd9);
	end

endmodule

// ==== src/line_formatter.sv ====
// report line formatter
// turns a duration and a pulse number into one 13-character uart line
module line_formatter
	import timer_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [4*duration_digits-1:0] duration_digits_in,
	input logic duration_done,
	input logic [4*number_digits-1:0] number_digits_in,
	input logic number_done,
	input logic busy,
	output logic [7:0] byte_data,
	output logic send,
	output logic sending
);

	localparam int index_width = $clog2(line_length + 1);

	logic [4*duration_digits-1:0] duration_value;
	logic [4*number_digits-1:0] number_value;
	logic duration_ready;
	logic number_ready;
	// 0..12 is the next character, 13 waits for the lf to leave
	logic [index_width-1:0] char_index;
	logic [7:0] next_char;
	logic issue;

	// one byte per idle uart, never on the cycle of our own send
	assign issue = sending && !busy && !send && (char_index != index_width'(line_length));

	// character for the current position, digits msd first
	always_comb begin
		if (char_index < index_width'(space_position))
			next_char = ascii_zero
				+ {4'h0, duration_value[4*(duration_digits-1-char_index) +: 4]};
		else if (char_index == index_width'(space_position))
			next_char = ascii_space;
		else if (char_index < index_width'(cr_position))
			next_char = ascii_zero + {4'h0, number_value[4*(cr_position-1-char_index) +: 4]};
		else if (char_index == index_width'(cr_position))
			next_char = ascii_cr;
		else
			next_char = ascii_lf;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			duration_ready <= 1'b0;
			number_ready <= 1'b0;
			char_index <= '0;
			send <= 1'b0;
			sending <= 1'b0;
		end else begin
			send <= issue;
			if (!sending) begin
				// results arriving mid-line are discarded
				if (duration_done)
					duration_ready <= 1'b1;
				if (number_done)
					number_ready <= 1'b1;
				if (duration_ready && number_ready) begin
					sending <= 1'b1;
					char_index <= '0;
					duration_ready <= 1'b0;
					number_ready <= 1'b0;
				end
			end else if (issue) begin
				char_index <= char_index + 1'b1;
			end else if (!busy && !send && char_index == index_width'(line_length)) begin
				// lf stop bit done
				sending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!sending && duration_done)
			duration_value <= duration_digits_in;
		if (!sending && number_done)
			number_value <= number_digits_in;
		if (issue)
			byte_data <= next_char;
	end

	// uart must be idle whenever a byte is offered
	assert property (@(posedge clock) disable iff (reset) send |-> !busy);

endmodule

// ==== src/uart_tx.sv ====
// uart transmitter, 8n1
// start bit, eight data bits lsb first, stop bit
module uart_tx #(
	parameter int clocks_per_bit = 868
) (
	input logic clock,
	input logic reset,
	input logic [7:0] byte_data,
	input logic send,
	output logic busy,
	output logic tx
);

	localparam int tick_width = (clocks_per_bit > 1) ? $clog2(clocks_per_bit) : 1;

	// stop, data, start; bit 0 on the line
	logic [9:0] frame;
	logic [tick_width-1:0] tick;
	logic [3:0] bit_count;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			tick <= '0;
			bit_count <= '0;
		end else if (!busy) begin
			if (send) begin
				busy <= 1'b1;
				tick <= '0;
				bit_count <= '0;
			end
		end else if (tick == tick_width'(clocks_per_bit - 1)) begin
			tick <= '0;
			// stop bit held its full time
			if (bit_count == 4'd9)
				busy <= 1'b0;
			else
				bit_count <= bit_count + 1'b1;
		end else begin
			tick <= tick + 1'b1;
		end
	end

	// byte latched on send, shifted at each bit boundary
	always_ff @(posedge clock) begin
		if (!busy && send)
			frame <= {1'b1, byte_data, 1'b0};
		else if (busy && tick == tick_width'(clocks_per_bit - 1))
			frame <= {1'b1, frame[9:1]};
	end

	// line idles high
	assign tx = busy ? frame[0] : 1'b1;

endmodule

// ==== src/duration_timer.sv ====
// pulse-duration timer top
// pulse timer, two decimal converters, line formatter, uart transmitter
module duration_timer
	import timer_pkg::*;
#(
	parameter int clocks_per_bit = 868
) (
	input logic clock,
	input logic reset,
	input logic trigger,
	output logic tx,
	output logic sending
);

	measurement_t measurement;
	logic measurement_valid;
	logic [4*duration_digits-1:0] duration_bcd;
	logic duration_done;
	logic [4*number_digits-1:0] number_bcd;
	logic number_done;
	logic [7:0] byte_data;
	logic send;
	logic busy;

	pulse_timer timer0 (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.measurement(measurement),
		.measurement_valid(measurement_valid)
	);

	// both converters start on the same strobe
	bin_to_bcd #(.input_width(duration_width), .number_of_digits(duration_digits)) duration_bcd0 (
		.clock(clock),
		.reset(reset),
		.start(measurement_valid),
		.binary(measurement.duration),
		.digits(duration_bcd),
		.done(duration_done)
	);

	bin_to_bcd #(.input_width(number_width), .number_of_digits(number_digits)) number_bcd0 (
		.clock(clock),
		.reset(reset),
		.start(measurement_valid),
		.binary(measurement.pulse_number),
		.digits(number_bcd),
		.done(number_done)
	);

	line_formatter formatter0 (
		.clock(clock),
		.reset(reset),
		.duration_digits_in(duration_bcd),
		.duration_done(duration_done),
		.number_digits_in(number_bcd),
		.number_done(number_done),
		.busy(busy),
		.byte_data(byte_data),
		.send(send),
		.sending(sending)
	);

	uart_tx #(.clocks_per_bit(clocks_per_bit)) uart0 (
		.clock(clock),
		.reset(reset),
		.byte_data(byte_data),
		.send(send),
		.busy(busy),
		.tx(tx)
	);

endmodule

// ==== test/duration_timer_tb.sv ====
// pulse-duration timer testbench
// drives pulses from a vector file and checks the uart lines decoded at tx
module duration_timer_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clock_period = 40;
	localparam int reset_cycles = 5;
	localparam int idle_cycles = 100;
	localparam int clocks_per_bit = 8;
	localparam int cycles_per_line = 1100;
	localparam int timeout_margin = 3000;
	localparam int quiet_cycles = 1200;
	localparam int max_duration = 999999;
	localparam int number_modulus = 10000;

	logic clock;
	logic reset;
	logic trigger;
	logic tx;
	logic sending;
	// expected lines in pulse order
	int expected_duration[$];
	int expected_number[$];
	int lines_expected;
	int lines_received;
	int error_count;
	int test_count;
	int tests_failed;
	int cycle_count;
	int cycle_limit;

	duration_timer #(.clocks_per_bit(clocks_per_bit)) dut0 (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.tx(tx),
		.sending(sending)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got %0h, expected %0h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic finish_test(input string label, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d %s: passed", test_count, label);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", test_count, label);
		end
	endtask

	// dddddd nnnn cr lf with leading zeros kept
	function automatic logic [7:0] line_char(input int duration, input int number,
			input int position);
		int divisor;
		divisor = 1;
		if (position < 6) begin
			repeat (5 - position) divisor = divisor * 10;
			return 8'h30 + 8'((duration / divisor) % 10);
		end else if (position == 6) begin
			return 8'h20;
		end else if (position < 11) begin
			repeat (10 - position) divisor = divisor * 10;
			return 8'h30 + 8'((number / divisor) % 10);
		end else if (position == 11) begin
			return 8'h0d;
		end
		return 8'h0a;
	endfunction

	// serial decoder sampling near mid-bit on falling edges
	initial begin : decoder
		logic [7:0] line_chars [13];
		logic [7:0] rx_byte;
		int char_count;
		int errors_before;
		int duration;
		int number;
		int wait_cycles;
		char_count = 0;
		errors_before = 0;
		forever begin
			@(negedge clock);
			if (!reset && tx === 1'b0) begin
				// a line's errors count from its first start bit
				if (char_count == 0)
					errors_before = error_count;
				repeat (clocks_per_bit / 2 - 1) @(negedge clock);
				check_value("tx start bit", tx, 0);
				check_value("sending", sending, 1);
				for (int i = 0; i < 8; i++) begin
					repeat (clocks_per_bit) @(negedge clock);
					rx_byte[i] = tx;
				end
				repeat (clocks_per_bit) @(negedge clock);
				check_value("tx stop bit", tx, 1);
				check_value("sending", sending, 1);
				line_chars[char_count] = rx_byte;
				char_count++;
				if (char_count == 13) begin
					char_count = 0;
					lines_received++;
					number = -1;
					if (expected_duration.size() == 0) begin
						$display("a report line arrived with no pulse pending");
						error_count++;
					end else begin
						duration = expected_duration.pop_front();
						number = expected_number.pop_front();
						for (int p = 0; p < 13; p++)
							check_value($sformatf("tx character %0d", p), line_chars[p],
								line_char(duration, number, p));
					end
					// sending drops right after the lf stop bit
					wait_cycles = 0;
					while (sending && wait_cycles < 2 * clocks_per_bit) begin
						@(negedge clock);
						wait_cycles++;
					end
					if (sending) begin
						$display("sending stayed high after the end of a line");
						error_count++;
					end
					finish_test($sformatf("line for pulse %0d", number), errors_before);
				end
			end
		end
	end

	initial begin : stimulus
		int fd;
		string text;
		int high_time;
		int low_time;
		int expect_line;
		int highs[$];
		int lows[$];
		int flags[$];
		int total_cycles;
		int pulse_index;
		int errors_before;
		reset = 1'b1;
		trigger = 1'b0;
		error_count = 0;
		test_count = 0;
		tests_failed = 0;
		lines_expected = 0;
		lines_received = 0;
		total_cycles = 0;
		fd = $fopen("test/pulse_vectors.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				if ($sscanf(text, "%d %d %d", high_time, low_time, expect_line) == 3) begin
					highs.push_back(high_time);
					lows.push_back(low_time);
					flags.push_back(expect_line);
					total_cycles += high_time + low_time;
					lines_expected += expect_line;
				end
			end
			$fclose(fd);
		end
		if (highs.size() == 0) begin
			$display("no pulse vectors could be read from test/pulse_vectors.txt");
			error_count++;
		end
		cycle_limit = reset_cycles + idle_cycles + total_cycles
			+ cycles_per_line * lines_expected + timeout_margin;
		// line stays idle through reset and before the first pulse
		errors_before = error_count;
		repeat (reset_cycles) begin
			@(negedge clock);
			check_value("tx", tx, 1);
			check_value("sending", sending, 0);
		end
		reset = 1'b0;
		repeat (idle_cycles) begin
			@(negedge clock);
			check_value("tx", tx, 1);
			check_value("sending", sending, 0);
		end
		finish_test("idle after reset", errors_before);
		// every pulse is numbered whether reported or not
		pulse_index = 0;
		foreach (highs[v]) begin
			pulse_index++;
			trigger = 1'b1;
			repeat (highs[v]) @(negedge clock);
			if (flags[v] != 0) begin
				check_value("sending", sending, 0);
				expected_duration.push_back(highs[v] > max_duration ? max_duration : highs[v]);
				expected_number.push_back(pulse_index % number_modulus);
			end
			trigger = 1'b0;
			repeat (lows[v]) @(negedge clock);
		end
		while (lines_received < lines_expected) @(negedge clock);
		// dropped pulses must not show up later
		repeat (quiet_cycles) @(negedge clock);
		errors_before = error_count;
		check_value("lines received", lines_received, lines_expected);
		finish_test("line count", errors_before);
		$display("tests: %0d run, %0d failed, %0d errors", test_count, tests_failed,
			error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// limit set from the vectors before the first rising edge
	initial begin : watchdog
		cycle_count = 0;
		@(posedge clock);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: no result after %0d clock cycles", cycle_limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== test/pulse_vectors.txt ====
// high_cycles low_cycles expect_line
// expect_line 0: pulse ends while the previous line is still sending
1 1500 1
2 1500 1
37 1500 1
1234 1500 1
99999 1500 1
1000100 1500 1
999999 1500 1
5 40 1
20 1500 0
300 1500 1
7 20 1
9 1500 0
4 1500 1

// ==== project.f ====
src/timer_pkg.sv
src/pulse_timer.sv
src/bin_to_bcd.sv
src/line_formatter.sv
src/uart_tx.sv
src/duration_timer.sv
test/duration_timer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pulse-duration timer testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module duration_timer_tb \
	-f project.f --Mdir obj_dir -o duration_timer_sim || exit 1
result=$(./obj_dir/duration_timer_sim)
echo "$result"
echo "$result" | grep -q "^=== PASS ===$" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
